// File: hdl/lsu_config.svh
// LSU configuration
// Data width, scoreboard id width and return-path pipeline depths

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 32

// Width of the scoreboard transaction id
`define LSU_TRANS_ID_BITS 3

// Extra register stages on the load and store return paths
`define LSU_NR_LOAD_PIPE_REGS 1
`define LSU_NR_STORE_PIPE_REGS 1

`endif

// File: hdl/lsu_pkg.sv
// LSU package
// Operation and exception encodings plus the records passed between stages

`include "lsu_config.svh"

`default_nettype none

package lsu_pkg;

  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // RISC-V mcause encodings
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    ST_ADDR_MISALIGNED = 4'd6
  } exc_cause_e;

  typedef struct packed {
    logic                 valid;
    exc_cause_e           cause;
    logic [`LSU_XLEN-1:0] tval;
  } exception_t;

  // ------------------------------------------------------------------------
  // Stage records
  // ------------------------------------------------------------------------

  typedef struct packed {
    lsu_op_e                       operation;
    logic [`LSU_XLEN-1:0]          operand_a;
    logic [`LSU_XLEN-1:0]          operand_b;
    // Two's complement offset
    logic [`LSU_XLEN-1:0]          imm;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                          valid;
    logic [`LSU_XLEN-1:0]          vaddr;
    logic [`LSU_XLEN-1:0]          data;
    logic [`LSU_XLEN/8-1:0]        be;
    lsu_op_e                       operation;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
  } lsu_ctrl_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]          paddr;
    logic [`LSU_XLEN-1:0]          data;
    logic [`LSU_XLEN/8-1:0]        be;
    lsu_op_e                       operation;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    exception_t                    exception;
  } lsu_xreq_t;

  typedef struct packed {
    logic                   req;
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_XLEN/8-1:0] be;
    logic [`LSU_XLEN-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic                          valid;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    logic [`LSU_XLEN-1:0]          result;
    exception_t                    exception;
  } ld_result_t;

  typedef struct packed {
    logic                          valid;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    exception_t                    exception;
  } st_result_t;

  // Transfer size as log2 of the byte count
  function automatic logic [1:0] lsu_size(lsu_op_e op);
    case (op)
      LH, LHU, SH: return 2'b01;
      LW, SW:      return 2'b10;
      default:     return 2'b00;
    endcase
  endfunction

  function automatic logic lsu_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

endpackage

`default_nettype wire

// File: hdl/lsu_pipe_reg.sv
// Valid/payload delay line
// Shifts a valid bit and a payload of any type by DEPTH cycles

`default_nettype none

module lsu_pipe_reg #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign valid_o = valid_i;
    assign data_o  = data_i;
  end else begin : gen_stages
    logic     [DEPTH-1:0] valid_q;
    payload_t             data_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= valid_i;
        for (int unsigned i = 1; i < DEPTH; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      data_q[0] <= data_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign valid_o = valid_q[DEPTH-1];
    assign data_o  = data_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// File: hdl/lsu_agu.sv
// Address generation unit
// Forms the effective address and byte enable, then registers the request

`include "lsu_config.svh"

`default_nettype none

module lsu_agu (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_valid_i,
  input  lsu_pkg::fu_data_t  fu_data_i,
  output lsu_pkg::lsu_ctrl_t lsu_ctrl_o
);

  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0]   vaddr;
  logic [`LSU_XLEN/8-1:0] be_mask;
  lsu_ctrl_t              ctrl_d;
  lsu_ctrl_t              ctrl_q;

  // Base plus offset, wraps modulo 2^XLEN
  assign vaddr = fu_data_i.operand_a + fu_data_i.imm;

  // ------------------------------------------------------------------------
  // Byte enable
  // ------------------------------------------------------------------------
  always_comb begin
    case (lsu_size(fu_data_i.operation))
      2'b00:   be_mask = 'd1;
      2'b01:   be_mask = 'd3;
      default: be_mask = '1;
    endcase
  end

  assign ctrl_d = '{
    valid:     lsu_valid_i,
    vaddr:     vaddr,
    data:      fu_data_i.operand_b,
    be:        be_mask << vaddr[1:0],
    operation: fu_data_i.operation,
    trans_id:  fu_data_i.trans_id
  };

  // ------------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------------
  // Payload only moves with an issued operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (lsu_valid_i) begin
      ctrl_q <= ctrl_d;
    end else begin
      ctrl_q.valid <= 1'b0;
    end
  end

  assign lsu_ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: hdl/lsu_addr_stage.sv
// Address stage
// Detects misaligned accesses, applies the identity translation with its
// one-cycle delay and routes the request to the load or store unit

`default_nettype none

module lsu_addr_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::lsu_ctrl_t lsu_ctrl_i,
  output lsu_pkg::lsu_xreq_t xreq_o,
  output logic               ld_valid_o,
  output logic               st_valid_o
);

  import lsu_pkg::*;

  logic       misaligned;
  exception_t misaligned_ex;
  lsu_xreq_t  xreq_d;
  logic       xreq_valid;

  // ------------------------------------------------------------------------
  // Misalignment check
  // ------------------------------------------------------------------------
  // Byte accesses are always aligned
  always_comb begin
    misaligned = 1'b0;
    case (lsu_size(lsu_ctrl_i.operation))
      2'b01:   misaligned = lsu_ctrl_i.vaddr[0];
      2'b10:   misaligned = |lsu_ctrl_i.vaddr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    misaligned_ex.valid = lsu_ctrl_i.valid & misaligned;
    misaligned_ex.cause = lsu_is_store(lsu_ctrl_i.operation) ? ST_ADDR_MISALIGNED
                                                             : LD_ADDR_MISALIGNED;
    misaligned_ex.tval  = misaligned ? lsu_ctrl_i.vaddr : '0;
  end

  // ------------------------------------------------------------------------
  // Identity translation
  // ------------------------------------------------------------------------
  // No MMU, so the physical address is the virtual one
  assign xreq_d = '{
    paddr:     lsu_ctrl_i.vaddr,
    data:      lsu_ctrl_i.data,
    be:        lsu_ctrl_i.be,
    operation: lsu_ctrl_i.operation,
    trans_id:  lsu_ctrl_i.trans_id,
    exception: misaligned_ex
  };

  // One stage, standing in for the translation lookup
  lsu_pipe_reg #(
    .payload_t(lsu_xreq_t),
    .DEPTH    (1)
  ) i_xlat_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(lsu_ctrl_i.valid),
    .data_i (xreq_d),
    .valid_o(xreq_valid),
    .data_o (xreq_o)
  );

  // Dispatch by operation class
  assign ld_valid_o = xreq_valid & ~lsu_is_store(xreq_o.operation);
  assign st_valid_o = xreq_valid & lsu_is_store(xreq_o.operation);

endmodule

`default_nettype wire

// File: hdl/load_unit.sv
// Load unit
// Strobes a word read, then aligns and extends the word returned one cycle later

`include "lsu_config.svh"

`default_nettype none

module load_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  lsu_pkg::lsu_xreq_t   xreq_i,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  logic [`LSU_XLEN-1:0] mem_rdata_i,
  output lsu_pkg::ld_result_t  result_o
);

  import lsu_pkg::*;

  logic                          valid_q;
  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_q;
  logic [1:0]                    offset_q;
  lsu_op_e                       op_q;
  exception_t                    ex_q;
  logic [`LSU_XLEN-1:0]          shifted;
  logic [`LSU_XLEN-1:0]          extended;

  // A faulting load never reaches memory
  assign mem_req_o.req   = valid_i & ~xreq_i.exception.valid;
  assign mem_req_o.addr  = {xreq_i.paddr[`LSU_XLEN-1:2], 2'b00};
  assign mem_req_o.be    = xreq_i.be;
  assign mem_req_o.wdata = '0;

  // ------------------------------------------------------------------------
  // Response tracking
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      trans_id_q <= xreq_i.trans_id;
      offset_q   <= xreq_i.paddr[1:0];
      op_q       <= xreq_i.operation;
      ex_q       <= xreq_i.exception;
    end
  end

  // ------------------------------------------------------------------------
  // Data alignment and extension
  // ------------------------------------------------------------------------
  assign shifted = mem_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      extended = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      LBU:     extended = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      LH:      extended = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      LHU:     extended = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  assign result_o = '{
    valid:     valid_q,
    trans_id:  trans_id_q,
    result:    ex_q.valid ? '0 : extended,
    exception: ex_q
  };

endmodule

`default_nettype wire

// File: hdl/store_unit.sv
// Store unit
// Strobes a lane-aligned write and reports completion in the same cycle

`include "lsu_config.svh"

`default_nettype none

module store_unit (
  input  logic                valid_i,
  input  lsu_pkg::lsu_xreq_t  xreq_i,
  output lsu_pkg::mem_req_t   mem_req_o,
  output lsu_pkg::st_result_t result_o
);

  import lsu_pkg::*;

  logic [1:0] offset;

  assign offset = xreq_i.paddr[1:0];

  // Write strobe, suppressed for a faulting store
  assign mem_req_o.req   = valid_i & ~xreq_i.exception.valid;
  assign mem_req_o.addr  = {xreq_i.paddr[`LSU_XLEN-1:2], 2'b00};
  // Byte enable already sits on the right lanes
  assign mem_req_o.be    = xreq_i.be;
  assign mem_req_o.wdata = xreq_i.data << {offset, 3'b000};

  // Completion
  assign result_o = '{
    valid:     valid_i,
    trans_id:  xreq_i.trans_id,
    exception: xreq_i.exception
  };

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
// Load/store unit top level
// Address generation, address stage, load and store units and return registers

`include "lsu_config.svh"

`default_nettype none

module lsu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_valid_i,
  input  lsu_pkg::fu_data_t    fu_data_i,
  output lsu_pkg::mem_req_t    ld_mem_req_o,
  input  logic [`LSU_XLEN-1:0] ld_mem_rdata_i,
  output lsu_pkg::mem_req_t    st_mem_req_o,
  output lsu_pkg::ld_result_t  load_result_o,
  output lsu_pkg::st_result_t  store_result_o
);

  import lsu_pkg::*;

  lsu_ctrl_t  lsu_ctrl;
  lsu_xreq_t  xreq;
  logic       ld_valid;
  logic       st_valid;
  ld_result_t ld_result;
  st_result_t st_result;
  logic       ld_pipe_valid;
  ld_result_t ld_pipe_data;
  logic       st_pipe_valid;
  st_result_t st_pipe_data;

  lsu_agu i_agu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lsu_valid_i(lsu_valid_i),
    .fu_data_i  (fu_data_i),
    .lsu_ctrl_o (lsu_ctrl)
  );

  lsu_addr_stage i_addr_stage (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .lsu_ctrl_i(lsu_ctrl),
    .xreq_o    (xreq),
    .ld_valid_o(ld_valid),
    .st_valid_o(st_valid)
  );

  load_unit i_load_unit (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (ld_valid),
    .xreq_i     (xreq),
    .mem_req_o  (ld_mem_req_o),
    .mem_rdata_i(ld_mem_rdata_i),
    .result_o   (ld_result)
  );

  store_unit i_store_unit (
    .valid_i  (st_valid),
    .xreq_i   (xreq),
    .mem_req_o(st_mem_req_o),
    .result_o (st_result)
  );

  // --------------------------------------------------------------------------
  // Return-path registers
  // --------------------------------------------------------------------------
  lsu_pipe_reg #(
    .payload_t(ld_result_t),
    .DEPTH    (`LSU_NR_LOAD_PIPE_REGS)
  ) i_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(ld_result.valid),
    .data_i (ld_result),
    .valid_o(ld_pipe_valid),
    .data_o (ld_pipe_data)
  );

  lsu_pipe_reg #(
    .payload_t(st_result_t),
    .DEPTH    (`LSU_NR_STORE_PIPE_REGS)
  ) i_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(st_result.valid),
    .data_i (st_result),
    .valid_o(st_pipe_valid),
    .data_o (st_pipe_data)
  );

  // Valid comes from the reset-cleared bit of the delay line
  assign load_result_o = '{
    valid:     ld_pipe_valid,
    trans_id:  ld_pipe_data.trans_id,
    result:    ld_pipe_data.result,
    exception: ld_pipe_data.exception
  };

  assign store_result_o = '{
    valid:     st_pipe_valid,
    trans_id:  st_pipe_data.trans_id,
    exception: st_pipe_data.exception
  };

endmodule

`default_nettype wire

// File: verification/lsu_tb.sv
// LSU testbench
// Fixed-seed random loads and stores against a memory model and a reference
// model, with exact latency, strobe and reset checks

`include "lsu_config.svh"

`default_nettype none

module lsu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int LD_LAT   = 3 + `LSU_NR_LOAD_PIPE_REGS;
  localparam int ST_LAT   = 2 + `LSU_NR_STORE_PIPE_REGS;
  localparam int REQ_LAT  = 2;
  localparam int MAX_WAIT = 50;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 lsu_valid_i;
  fu_data_t             fu_data_i;
  mem_req_t             ld_mem_req_o;
  logic [`LSU_XLEN-1:0] ld_mem_rdata_i;
  mem_req_t             st_mem_req_o;
  ld_result_t           load_result_o;
  st_result_t           store_result_o;

  // External memory and the reference copy, both indexed by address bits 9:2
  logic [31:0] mem     [256];
  logic [31:0] ref_mem [256];

  ld_result_t exp_ld_q[$];
  int         ld_op_q[$];
  st_result_t exp_st_q[$];
  int         st_op_q[$];
  mem_req_t   exp_rd_q[$];
  int         rd_op_q[$];
  mem_req_t   exp_wr_q[$];
  int         wr_op_q[$];
  int         issue_at[int];
  string      op_label[int];

  string                         phase;
  int                            cycle_cnt;
  int                            op_cnt;
  int                            n_checks;
  int                            n_errors;
  logic [`LSU_TRANS_ID_BITS-1:0] next_id;

  lsu_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsu_valid_i   (lsu_valid_i),
    .fu_data_i     (fu_data_i),
    .ld_mem_req_o  (ld_mem_req_o),
    .ld_mem_rdata_i(ld_mem_rdata_i),
    .st_mem_req_o  (st_mem_req_o),
    .load_result_o (load_result_o),
    .store_result_o(store_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx * 32'h9e37_79b1) ^ {4{idx[7:0]}};
  endfunction

  // --------------------------------------------------------------------------
  // Memory model
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (st_mem_req_o.req) begin
      for (int b = 0; b < 4; b++) begin
        if (st_mem_req_o.be[b]) begin
          mem[st_mem_req_o.addr[9:2]][8*b +: 8] <= st_mem_req_o.wdata[8*b +: 8];
        end
      end
    end
    // Read data is due one cycle after the strobe
    if (ld_mem_req_o.req) begin
      ld_mem_rdata_i <= mem[ld_mem_req_o.addr[9:2]];
    end
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic model_issue(input fu_data_t fu);
    logic [31:0] addr;
    logic [31:0] word;
    logic [3:0]  mask;
    logic        is_st;
    logic        mis;
    int          nbytes;
    exception_t  ex;
    mem_req_t    req;
    addr   = fu.operand_a + fu.imm;
    is_st  = fu.operation inside {SB, SH, SW};
    nbytes = (fu.operation inside {LW, SW}) ? 4 : (fu.operation inside {LH, LHU, SH}) ? 2 : 1;
    mis    = (addr % nbytes) != 0;
    mask   = (nbytes == 4) ? 4'hf : (nbytes == 2) ? 4'h3 : 4'h1;
    mask   = mask << addr[1:0];
    ex.valid = mis;
    ex.tval  = addr;
    if (is_st) ex.cause = ST_ADDR_MISALIGNED;
    else ex.cause = LD_ADDR_MISALIGNED;
    req = '{req: 1'b1, addr: {addr[31:2], 2'b00}, be: mask, wdata: '0};
    op_cnt++;
    issue_at[op_cnt] = cycle_cnt;
    op_label[op_cnt] = $sformatf("%s #%0d %s @%08h", phase, op_cnt, fu.operation.name(), addr);
    if (is_st) begin
      req.wdata = fu.operand_b << (8 * addr[1:0]);
      if (!mis) begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) ref_mem[addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
        end
        exp_wr_q.push_back(req);
        wr_op_q.push_back(op_cnt);
      end
      exp_st_q.push_back('{valid: 1'b1, trans_id: fu.trans_id, exception: ex});
      st_op_q.push_back(op_cnt);
    end else begin
      word = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
      case (fu.operation)
        LB:      word = 32'($signed(word[7:0]));
        LBU:     word = 32'(word[7:0]);
        LH:      word = 32'($signed(word[15:0]));
        LHU:     word = 32'(word[15:0]);
        default: word = word;
      endcase
      if (mis) begin
        word = '0;
      end else begin
        exp_rd_q.push_back(req);
        rd_op_q.push_back(op_cnt);
      end
      exp_ld_q.push_back('{valid: 1'b1, trans_id: fu.trans_id, result: word, exception: ex});
      ld_op_q.push_back(op_cnt);
    end
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic report_fault(input string msg);
    n_errors++;
    $display("%s", msg);
  endtask

  // Cause and tval carry no meaning without a valid exception
  function automatic exception_t clean_exception(input exception_t e);
    return e.valid ? e : '0;
  endfunction

  task automatic check_load(input string name, input ld_result_t exp, input ld_result_t act);
    exp.exception = clean_exception(exp.exception);
    act.exception = clean_exception(act.exception);
    n_checks++;
    if (act !== exp) begin
      report_fault($sformatf("error %s: load expected %h actual %h", name, exp, act));
    end else begin
      $display("ok    %s: load result %08h", name, act.result);
    end
  endtask

  task automatic check_store(input string name, input st_result_t exp, input st_result_t act);
    exp.exception = clean_exception(exp.exception);
    act.exception = clean_exception(act.exception);
    n_checks++;
    if (act !== exp) begin
      report_fault($sformatf("error %s: store expected %h actual %h", name, exp, act));
    end else begin
      $display("ok    %s: store done", name);
    end
  endtask

  task automatic check_strobe(input string name, input mem_req_t exp, input mem_req_t act);
    n_checks++;
    if (act !== exp) begin
      report_fault($sformatf("error %s: strobe expected %h actual %h", name, exp, act));
    end else begin
      $display("ok    %s: strobe %08h be %b", name, act.addr, act.be);
    end
  endtask

  task automatic check_latency(input string name, input int num, input int lat);
    if (cycle_cnt - issue_at[num] != lat) begin
      report_fault($sformatf("error %s: latency expected %0d actual %0d", name, lat,
                             cycle_cnt - issue_at[num]));
    end
  endtask

  task automatic check_reset_quiet();
    logic [3:0] active;
    active = {load_result_o.valid, store_result_o.valid, ld_mem_req_o.req, st_mem_req_o.req};
    n_checks++;
    if (active !== 4'b0000) begin
      report_fault($sformatf("error reset: valid and req bits expected %b actual %b",
                             4'b0000, active));
    end else begin
      $display("ok    reset: outputs quiet in cycle %0d", cycle_cnt);
    end
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  task automatic watch_outputs();
    int       num;
    mem_req_t rd;
    if (load_result_o.valid) begin
      if (ld_op_q.size() == 0) begin
        report_fault("a load result arrived with no load in flight");
      end else begin
        num = ld_op_q.pop_front();
        check_latency({op_label[num], " load"}, num, LD_LAT);
        check_load(op_label[num], exp_ld_q.pop_front(), load_result_o);
      end
    end
    if (store_result_o.valid) begin
      if (st_op_q.size() == 0) begin
        report_fault("a store result arrived with no store in flight");
      end else begin
        num = st_op_q.pop_front();
        check_latency({op_label[num], " store"}, num, ST_LAT);
        check_store(op_label[num], exp_st_q.pop_front(), store_result_o);
      end
    end
    if (ld_mem_req_o.req) begin
      if (rd_op_q.size() == 0) begin
        report_fault("a read strobe appeared with no aligned load in flight");
      end else begin
        num = rd_op_q.pop_front();
        rd = ld_mem_req_o;
        rd.wdata = '0;
        check_latency({op_label[num], " read"}, num, REQ_LAT);
        check_strobe({op_label[num], " read"}, exp_rd_q.pop_front(), rd);
      end
    end
    if (st_mem_req_o.req) begin
      if (wr_op_q.size() == 0) begin
        report_fault("a write strobe appeared with no aligned store in flight");
      end else begin
        num = wr_op_q.pop_front();
        check_latency({op_label[num], " write"}, num, REQ_LAT);
        check_strobe({op_label[num], " write"}, exp_wr_q.pop_front(), st_mem_req_o);
      end
    end
  endtask

  always @(negedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (!rst_ni) begin
      check_reset_quiet();
    end else begin
      if (lsu_valid_i) model_issue(fu_data_i);
      watch_outputs();
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic issue_op(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] imm;
    // Random 12-bit signed offset, base chosen to hit the target address
    imm = 32'($signed(12'($urandom)));
    @(posedge clk_i);
    lsu_valid_i <= 1'b1;
    fu_data_i   <= '{operation: op, operand_a: addr - imm, operand_b: data, imm: imm,
                     trans_id: next_id};
    next_id = next_id + 1'b1;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(posedge clk_i);
    lsu_valid_i <= 1'b0;
    while ((ld_op_q.size() + st_op_q.size() + rd_op_q.size() + wr_op_q.size()) != 0 &&
           waited < MAX_WAIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (waited >= MAX_WAIT) begin
      report_fault($sformatf("timed out in %s waiting for outstanding results", phase));
    end
  endtask

  initial begin
    logic [31:0] addr;
    void'($urandom(19));
    rst_ni         = 1'b0;
    // An aligned load held on the input while reset is active
    lsu_valid_i    = 1'b1;
    fu_data_i      = '{operation: LW, operand_a: 32'h40, operand_b: '0, imm: '0,
                       trans_id: '0};
    ld_mem_rdata_i = '0;
    next_id        = '0;
    cycle_cnt      = 0;
    op_cnt         = 0;
    n_checks       = 0;
    n_errors       = 0;
    phase          = "reset";
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (2) @(posedge clk_i);
    rst_ni      <= 1'b1;
    lsu_valid_i <= 1'b0;

    // Each store is read back with every load form
    phase = "aligned";
    for (int n = 0; n < 8; n++) begin
      addr = $urandom & 32'hffff_fffc;
      case (n % 3)
        0:       issue_op(SB, addr + $urandom_range(3), $urandom);
        1:       issue_op(SH, addr + 2 * $urandom_range(1), $urandom);
        default: issue_op(SW, addr, $urandom);
      endcase
      for (int off = 0; off < 4; off++) begin
        issue_op(LB, addr + off, '0);
        issue_op(LBU, addr + off, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue_op(LH, addr + off, '0);
        issue_op(LHU, addr + off, '0);
      end
      issue_op(LW, addr, '0);
    end
    wait_idle();

    phase = "misaligned";
    for (int off = 1; off < 4; off++) begin
      addr = ($urandom & 32'hffff_fffc) + off;
      issue_op(LW, addr, '0);
      issue_op(SW, addr, $urandom);
      if (off != 2) begin
        issue_op(LH, addr, '0);
        issue_op(LHU, addr, '0);
        issue_op(SH, addr, $urandom);
      end
    end
    wait_idle();

    phase = "store_lanes";
    addr = $urandom & 32'hffff_fffc;
    for (int off = 0; off < 4; off++) begin
      issue_op(SB, addr + off, $urandom);
    end
    issue_op(SH, addr, $urandom);
    issue_op(SH, addr + 2, $urandom);
    issue_op(LW, addr, '0);
    issue_op(SW, addr, $urandom);
    issue_op(LW, addr, '0);
    wait_idle();

    // Small window of words so loads often hit recent stores
    phase = "random";
    for (int n = 0; n < 64; n++) begin
      addr = ($urandom & 32'hffff_fc00) | $urandom_range(63);
      issue_op(lsu_op_e'($urandom_range(7)), addr, $urandom);
    end
    wait_idle();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_pipe_reg.sv
hdl/lsu_agu.sv
hdl/lsu_addr_stage.sv
hdl/load_unit.sv
hdl/store_unit.sv
hdl/lsu_top.sv
verification/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_pipe_reg.sv
      - hdl/lsu_agu.sv
      - hdl/lsu_addr_stage.sv
      - hdl/load_unit.sv
      - hdl/store_unit.sv
      - hdl/lsu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/lsu_tb.sv
